//--- build.f
+incdir+source
source/dbg_pkg.sv
source/tap_ctrl.sv
source/dmi_scan.sv
source/dmi_regs.sv
source/sb_mem.sv
source/jtag_dbg_top.sv
verif/tb_jtag_dbg.sv

//--- Bender.yml
package:
  name: jtag_dbg

sources:
  - include_dirs:
      - source
    files:
      - source/dbg_pkg.sv
      - source/tap_ctrl.sv
      - source/dmi_scan.sv
      - source/dmi_regs.sv
      - source/sb_mem.sv
      - source/jtag_dbg_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - verif/tb_jtag_dbg.sv

//--- verif/tb_jtag_dbg.sv
/*
 * JTAG debug transport testbench
 * Random JTAG scans against a reference model of the debug registers and memory
 */

`timescale 1ns/1ps
`default_nettype none

`include "dbg_defs.svh"

module tb_jtag_dbg;

  localparam logic [31:0] SEED = 32'h1a1a2f78;
  localparam logic [31:0] POLY = 32'h8020_0003;

  localparam logic [1:0] OP_NOP   = 2'd0;
  localparam logic [1:0] OP_READ  = 2'd1;
  localparam logic [1:0] OP_WRITE = 2'd2;

  localparam int IDLE_CYC  = 5;
  localparam int N_ROUNDS  = 3;
  localparam int N_BURSTS  = 2;
  localparam int BURST_LEN = 8;
  localparam int N_ROA     = 4;

  // DMI scans of the register, burst, read-on-address, read-on-data and error tests
  localparam int DMI_SCANS = 6 * N_ROUNDS + 2 + 1 + N_BURSTS * (1 + BURST_LEN)
                           + 1 + 3 * N_ROA + 2 + 2 * BURST_LEN + 16;
  localparam int SCAN_CYC  = DMI_SCANS * (`DBG_DMI_LEN + 5 + IDLE_CYC)
                           + 3 * (32 + 5 + IDLE_CYC) + 3 * (11 + IDLE_CYC)
                           + 8 + 1 + 8 + 5 + 1;
  localparam int TIMEOUT_CYC = 2 * SCAN_CYC;

  logic jtag_tck;
  logic rst_n_i;
  logic tms_i;
  logic tdi_i;
  logic tdo_o;

  logic [31:0] lfsr_q;
  int          checks;
  int          errors;
  int          cycle_cnt;

  // Reference model state
  logic        m_dmactive;
  logic        m_rd_on_addr;
  logic        m_auto_inc;
  logic        m_rd_on_data;
  logic [2:0]  m_sberror;
  logic [31:0] m_addr;
  logic [31:0] m_data;
  logic [31:0] m_mem [`DBG_MEM_WORDS];

  jtag_dbg_top DUT (
    .jtag_tck(jtag_tck),
    .rst_n_i (rst_n_i),
    .tms_i   (tms_i),
    .tdi_i   (tdi_i),
    .tdo_o   (tdo_o)
  );

  always #2 jtag_tck = ~jtag_tck;

  always @(posedge jtag_tck) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYC) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYC);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // Galois LFSR stepped once for each bit taken
  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ POLY) : (lfsr_q >> 1);
      r[i]   = lfsr_q[0];
    end
    return r;
  endfunction

  task automatic check_equal(input string name, input logic [63:0] exp,
                             input logic [63:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("[ERROR] %s: expected %0h, actual %0h", name, exp, act);
    end
  endtask

  ////////////////////
  // JTAG pin level
  ////////////////////

  // TDO is read before the edge that shifts
  task automatic clock_bit(input logic tms, input logic tdi, output logic tdo);
    @(posedge jtag_tck);
    tms_i <= tms;
    tdi_i <= tdi;
    @(negedge jtag_tck);
    tdo = tdo_o;
  endtask

  task automatic step_tms(input logic tms);
    logic unused;
    clock_bit(tms, 1'b0, unused);
  endtask

  task automatic idle(input int n);
    repeat (n) step_tms(1'b0);
  endtask

  // From Run-Test/Idle back to Run-Test/Idle
  task automatic dr_scan(input int n, input logic [63:0] din, output logic [63:0] dout);
    logic t;
    dout = '0;
    step_tms(1'b1);
    step_tms(1'b0);
    step_tms(1'b0);
    for (int i = 0; i < n; i++) begin
      clock_bit(i == n - 1, din[i], t);
      dout[i] = t;
    end
    step_tms(1'b1);
    step_tms(1'b0);
    idle(IDLE_CYC);
  endtask

  task automatic ir_scan(input logic [4:0] ir, output logic [4:0] out);
    logic t;
    step_tms(1'b1);
    step_tms(1'b1);
    step_tms(1'b0);
    step_tms(1'b0);
    for (int i = 0; i < 5; i++) begin
      clock_bit(i == 4, ir[i], t);
      out[i] = t;
    end
    step_tms(1'b1);
    step_tms(1'b0);
    idle(IDLE_CYC);
  endtask

  task automatic dmi_access(input logic [1:0] op, input logic [6:0] addr,
                            input logic [31:0] data, output logic [63:0] cap);
    dr_scan(`DBG_DMI_LEN, {23'b0, addr, data, op}, cap);
  endtask

  ////////////////////
  // Reference model
  ////////////////////

  task automatic model_bus(input logic we, input logic [31:0] addr, input logic [31:0] wdata);
    if (addr >= `DBG_MEM_WORDS * 4) begin
      m_sberror = 3'd2;
    end else if (we) begin
      m_mem[addr[5:2]] = wdata;
    end else begin
      m_data = m_mem[addr[5:2]];
    end
  endtask

  task automatic model_write(input logic [6:0] addr, input logic [31:0] d);
    case (addr)
      `DBG_ADDR_DMCONTROL: m_dmactive = d[0];
      `DBG_ADDR_SBCS: begin
        m_rd_on_addr = d[20];
        m_auto_inc   = d[16];
        m_rd_on_data = d[15];
        m_sberror    = m_sberror & ~d[14:12];
      end
      `DBG_ADDR_SBADDR0: begin
        m_addr = d;
        if (m_rd_on_addr && m_sberror == 3'd0) begin
          model_bus(1'b0, d, 32'd0);
          if (m_auto_inc) m_addr = d + 32'd4;
        end
      end
      `DBG_ADDR_SBDATA0: begin
        m_data = d;
        if (m_sberror == 3'd0) begin
          model_bus(1'b1, m_addr, d);
          if (m_auto_inc) m_addr = m_addr + 32'd4;
        end
      end
      default: ;
    endcase
  endtask

  // Returns the value before any read-on-data access
  task automatic model_read(input logic [6:0] addr, output logic [31:0] d);
    d = '0;
    case (addr)
      `DBG_ADDR_DMCONTROL: d = {31'b0, m_dmactive};
      `DBG_ADDR_SBCS: d = {11'b0, m_rd_on_addr, 3'd2, m_auto_inc, m_rd_on_data,
                           m_sberror, 12'b0};
      `DBG_ADDR_SBADDR0: d = m_addr;
      `DBG_ADDR_SBDATA0: begin
        d = m_data;
        if (m_rd_on_data && m_sberror == 3'd0) begin
          model_bus(1'b0, m_addr, 32'd0);
          if (m_auto_inc) m_addr = m_addr + 32'd4;
        end
      end
      default: ;
    endcase
  endtask

  task automatic reg_write(input logic [6:0] addr, input logic [31:0] d);
    logic [63:0] cap;
    dmi_access(OP_WRITE, addr, d, cap);
    model_write(addr, d);
  endtask

  // Result comes back on the capture of the following nop scan
  task automatic reg_read(input string name, input logic [6:0] addr);
    logic [31:0] exp;
    logic [63:0] cap;
    model_read(addr, exp);
    dmi_access(OP_READ, addr, 32'd0, cap);
    dmi_access(OP_NOP, 7'd0, 32'd0, cap);
    check_equal(name, {23'b0, addr, exp, 2'b00}, cap);
  endtask

  ////////////////////
  // Test sequence
  ////////////////////

  initial begin
    logic [63:0] dout;
    logic [31:0] r;
    logic [4:0]  ir_out;
    jtag_tck  = 1'b0;
    rst_n_i   = 1'b0;
    tms_i     = 1'b1;
    tdi_i     = 1'b0;
    lfsr_q    = SEED;
    checks    = 0;
    errors    = 0;
    cycle_cnt = 0;
    m_dmactive   = 1'b0;
    m_rd_on_addr = 1'b0;
    m_auto_inc   = 1'b0;
    m_rd_on_data = 1'b0;
    m_sberror    = 3'd0;
    m_addr       = '0;
    m_data       = '0;
    for (int i = 0; i < `DBG_MEM_WORDS; i++) begin
      m_mem[i] = '0;
    end
    repeat (8) @(posedge jtag_tck);
    rst_n_i <= 1'b1;
    step_tms(1'b0);

    // IDCODE after reset and again after a TMS reset from a random state
    dr_scan(32, {32'b0, random_bits(32)}, dout);
    check_equal("idcode_after_reset", `DBG_IDCODE, dout);
    // Leave IDCODE so that the TMS reset has to reload it
    ir_scan(`DBG_IR_BYPASS, ir_out);
    for (int i = 0; i < 8; i++) begin
      r = random_bits(1);
      step_tms(r[0]);
    end
    repeat (5) step_tms(1'b1);
    step_tms(1'b0);
    dr_scan(32, {32'b0, random_bits(32)}, dout);
    check_equal("idcode_after_tms_reset", `DBG_IDCODE, dout);

    // BYPASS delays by one bit
    ir_scan(`DBG_IR_BYPASS, ir_out);
    check_equal("ir_capture", 5'b00001, ir_out);
    r = random_bits(32);
    dr_scan(32, {32'b0, r}, dout);
    check_equal("bypass_delay", {r[30:0], 1'b0}, dout);

    ir_scan(`DBG_IR_DMI, ir_out);
    for (int i = 0; i < N_ROUNDS; i++) begin
      reg_write(`DBG_ADDR_DMCONTROL, random_bits(32));
      reg_read("dmcontrol_readback", `DBG_ADDR_DMCONTROL);
    end
    for (int i = 0; i < N_ROUNDS; i++) begin
      reg_write(`DBG_ADDR_SBCS, random_bits(32));
      reg_read("sbcs_readback", `DBG_ADDR_SBCS);
    end
    reg_read("unknown_reg", 7'h20);

    // Write bursts with auto-increment
    reg_write(`DBG_ADDR_SBCS, 32'h0001_0000);
    for (int b = 0; b < N_BURSTS; b++) begin
      r = random_bits(3);
      reg_write(`DBG_ADDR_SBADDR0, {r[2:0], 2'b00});
      for (int i = 0; i < BURST_LEN; i++) begin
        reg_write(`DBG_ADDR_SBDATA0, random_bits(32));
      end
    end
    reg_write(`DBG_ADDR_SBCS, 32'h0010_0000);
    for (int i = 0; i < N_ROA; i++) begin
      r = random_bits(4);
      reg_write(`DBG_ADDR_SBADDR0, {r[3:0], 2'b00});
      reg_read("read_on_addr", `DBG_ADDR_SBDATA0);
    end
    reg_write(`DBG_ADDR_SBCS, 32'h0011_8000);
    r = random_bits(3);
    reg_write(`DBG_ADDR_SBADDR0, {r[2:0], 2'b00});
    for (int i = 0; i < BURST_LEN; i++) begin
      reg_read("read_on_data", `DBG_ADDR_SBDATA0);
    end

    // Bad address sets a sticky sberror
    reg_write(`DBG_ADDR_SBCS, 32'h0010_0000);
    r = random_bits(4);
    reg_write(`DBG_ADDR_SBADDR0, 32'h40 + {r[3:0], 2'b00});
    reg_read("sberror_set", `DBG_ADDR_SBCS);
    reg_write(`DBG_ADDR_SBDATA0, random_bits(32));
    r = random_bits(4);
    reg_write(`DBG_ADDR_SBADDR0, {r[3:0], 2'b00});
    reg_read("blocked_data", `DBG_ADDR_SBDATA0);
    reg_read("sberror_sticky", `DBG_ADDR_SBCS);
    reg_write(`DBG_ADDR_SBCS, 32'h0010_7000);
    reg_read("sberror_cleared", `DBG_ADDR_SBCS);
    r = random_bits(4);
    reg_write(`DBG_ADDR_SBADDR0, {r[3:0], 2'b00});
    reg_read("access_after_clear", `DBG_ADDR_SBDATA0);

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- source/jtag_dbg_top.sv
/*
 * JTAG debug transport top
 * TAP, DMI scan, debug registers and bus memory in one pipeline
 */

`timescale 1ns/1ps
`default_nettype none

`include "dbg_defs.svh"

module jtag_dbg_top (
  input  wire  jtag_tck,
  input  wire  rst_n_i,
  input  wire  tms_i,
  input  wire  tdi_i,
  output logic tdo_o
);

  logic              dr_capture;
  logic              dr_shift;
  logic              dr_update;
  logic              dmi_tdo;
  logic              dmi_req_valid;
  dbg_pkg::dmi_req_t dmi_req;
  dbg_pkg::dmi_rsp_t dmi_rsp;
  logic              sb_valid;
  dbg_pkg::sb_req_t  sb_req;
  dbg_pkg::sb_rsp_t  sb_rsp;

  tap_ctrl i_tap_ctrl (
    .jtag_tck    (jtag_tck),
    .rst_n_i     (rst_n_i),
    .tms_i       (tms_i),
    .tdi_i       (tdi_i),
    .dmi_tdo_i   (dmi_tdo),
    .tdo_o       (tdo_o),
    .dr_capture_o(dr_capture),
    .dr_shift_o  (dr_shift),
    .dr_update_o (dr_update)
  );

  dmi_scan i_dmi_scan (
    .jtag_tck    (jtag_tck),
    .rst_n_i     (rst_n_i),
    .tdi_i       (tdi_i),
    .dr_capture_i(dr_capture),
    .dr_shift_i  (dr_shift),
    .dr_update_i (dr_update),
    .rsp_i       (dmi_rsp),
    .tdo_o       (dmi_tdo),
    .req_valid_o (dmi_req_valid),
    .req_o       (dmi_req)
  );

  dmi_regs i_dmi_regs (
    .jtag_tck   (jtag_tck),
    .rst_n_i    (rst_n_i),
    .req_valid_i(dmi_req_valid),
    .req_i      (dmi_req),
    .sb_rsp_i   (sb_rsp),
    .rsp_o      (dmi_rsp),
    .sb_valid_o (sb_valid),
    .sb_req_o   (sb_req)
  );

  sb_mem i_sb_mem (
    .jtag_tck  (jtag_tck),
    .rst_n_i   (rst_n_i),
    .sb_valid_i(sb_valid),
    .sb_req_i  (sb_req),
    .sb_rsp_o  (sb_rsp)
  );

endmodule

`default_nettype wire

//--- source/sb_mem.sv
/*
 * System bus word memory
 * Registered read data, writes and an error flag for out-of-range addresses
 */

`timescale 1ns/1ps
`default_nettype none

`include "dbg_defs.svh"

module sb_mem (
  input  wire                   jtag_tck,
  input  wire                   rst_n_i,
  input  wire                   sb_valid_i,
  input  wire dbg_pkg::sb_req_t sb_req_i,
  output dbg_pkg::sb_rsp_t      sb_rsp_o
);

  import dbg_pkg::*;

  localparam int unsigned IDX_W = $clog2(`DBG_MEM_WORDS);

  logic [31:0]      mem_q [`DBG_MEM_WORDS];
  logic [IDX_W-1:0] idx;
  logic             bad_addr;

  assign idx      = sb_req_i.addr[IDX_W+1:2];
  assign bad_addr = (sb_req_i.addr >= 32'(`DBG_MEM_WORDS * 4));

  always_ff @(posedge jtag_tck) begin
    if (!rst_n_i) begin
      for (int i = 0; i < `DBG_MEM_WORDS; i++) begin
        mem_q[i] <= '0;
      end
      sb_rsp_o <= '0;
    end else if (sb_valid_i) begin
      sb_rsp_o.err   <= bad_addr;
      sb_rsp_o.rdata <= bad_addr ? '0 : mem_q[idx];
      if (sb_req_i.we && !bad_addr) begin
        mem_q[idx] <= sb_req_i.wdata;
      end
    end
  end

  // Only word accesses come from the debug registers
  a_word_aligned: assert property (@(posedge jtag_tck) disable iff (!rst_n_i)
    sb_valid_i |-> (sb_req_i.addr[1:0] == 2'b00));

endmodule

`default_nettype wire

//--- source/dmi_regs.sv
/*
 * Debug module registers
 * DMControl, SBCS, SBAddress0 and SBData0 decode with system bus access launch
 */

`timescale 1ns/1ps
`default_nettype none

`include "dbg_defs.svh"

module dmi_regs (
  input  wire                    jtag_tck,
  input  wire                    rst_n_i,
  input  wire                    req_valid_i,
  input  wire dbg_pkg::dmi_req_t req_i,
  input  wire dbg_pkg::sb_rsp_t  sb_rsp_i,
  output dbg_pkg::dmi_rsp_t      rsp_o,
  output logic                   sb_valid_o,
  output dbg_pkg::sb_req_t       sb_req_o
);

  import dbg_pkg::*;

  logic        dmactive_q;
  logic        rd_on_addr_q;
  logic        auto_inc_q;
  logic        rd_on_data_q;
  logic [2:0]  sberror_q;
  logic [31:0] sbaddr_q;
  logic [31:0] sbdata_q;
  logic        pend_q;

  sbcs_t       sbcs_rd;
  sbcs_t       sbcs_wr;
  logic        is_rd;
  logic        is_wr;
  logic [31:0] rdata;
  logic        launch;
  logic        launch_we;
  logic [31:0] launch_addr;
  logic [31:0] launch_wdata;

  always_comb begin
    sbcs_rd                 = '0;
    sbcs_rd.sbreadonaddr    = rd_on_addr_q;
    sbcs_rd.sbaccess        = 3'd2;
    sbcs_rd.sbautoincrement = auto_inc_q;
    sbcs_rd.sbreadondata    = rd_on_data_q;
    sbcs_rd.sberror         = sberror_q;
  end

  assign sbcs_wr = req_i.data;
  assign is_rd   = (req_i.op == DMI_OP_READ);
  assign is_wr   = (req_i.op == DMI_OP_WRITE);

  ////////////////////
  // Register decode
  ////////////////////

  always_comb begin
    rdata        = '0;
    launch       = 1'b0;
    launch_we    = 1'b0;
    launch_addr  = sbaddr_q;
    launch_wdata = sbdata_q;
    case (req_i.addr)
      `DBG_ADDR_DMCONTROL: rdata = {31'b0, dmactive_q};
      `DBG_ADDR_SBCS:      rdata = sbcs_rd;
      `DBG_ADDR_SBADDR0: begin
        rdata = sbaddr_q;
        if (is_wr && rd_on_addr_q) begin
          launch      = 1'b1;
          launch_addr = req_i.data;
        end
      end
      `DBG_ADDR_SBDATA0: begin
        rdata = sbdata_q;
        if (is_wr) begin
          launch       = 1'b1;
          launch_we    = 1'b1;
          launch_wdata = req_i.data;
        end else if (rd_on_data_q) begin
          launch = 1'b1;
        end
      end
      default: ;
    endcase
    // A sticky bus error blocks every access
    launch = launch && req_valid_i && (sberror_q == 3'd0);
  end

  always_ff @(posedge jtag_tck) begin
    if (!rst_n_i) begin
      dmactive_q   <= 1'b0;
      rd_on_addr_q <= 1'b0;
      auto_inc_q   <= 1'b0;
      rd_on_data_q <= 1'b0;
      sberror_q    <= 3'd0;
      sbaddr_q     <= '0;
      sbdata_q     <= '0;
      pend_q       <= 1'b0;
      sb_valid_o   <= 1'b0;
      rsp_o        <= '0;
    end else begin
      sb_valid_o <= launch;
      pend_q     <= sb_valid_o;
      if (req_valid_i) begin
        rsp_o.data   <= is_rd ? rdata : '0;
        rsp_o.status <= 2'd0;
      end
      if (req_valid_i && is_wr) begin
        case (req_i.addr)
          `DBG_ADDR_DMCONTROL: dmactive_q <= req_i.data[0];
          `DBG_ADDR_SBCS: begin
            rd_on_addr_q <= sbcs_wr.sbreadonaddr;
            auto_inc_q   <= sbcs_wr.sbautoincrement;
            rd_on_data_q <= sbcs_wr.sbreadondata;
            sberror_q    <= sberror_q & ~sbcs_wr.sberror;
          end
          `DBG_ADDR_SBADDR0: sbaddr_q <= req_i.data;
          `DBG_ADDR_SBDATA0: sbdata_q <= req_i.data;
          default: ;
        endcase
      end
      if (launch && auto_inc_q) begin
        sbaddr_q <= launch_addr + 32'd4;
      end
      // Bus result arrives one cycle after the strobe
      if (pend_q) begin
        if (sb_rsp_i.err) begin
          sberror_q <= 3'd2;
        end else if (!sb_req_o.we) begin
          sbdata_q <= sb_rsp_i.rdata;
        end
      end
    end
  end

  always_ff @(posedge jtag_tck) begin
    if (launch) begin
      sb_req_o.we    <= launch_we;
      sb_req_o.addr  <= launch_addr;
      sb_req_o.wdata <= launch_wdata;
    end
  end

  // No new access until the previous result has been taken
  a_no_overlap: assert property (@(posedge jtag_tck) disable iff (!rst_n_i)
    sb_valid_o |-> ##1 (!sb_valid_o) [*2]);

endmodule

`default_nettype wire

//--- source/dmi_scan.sv
/*
 * DMI scan register
 * Captures the last response, shifts LSB first, issues a request on Update-DR
 */

`timescale 1ns/1ps
`default_nettype none

`include "dbg_defs.svh"

module dmi_scan (
  input  wire                jtag_tck,
  input  wire                rst_n_i,
  input  wire                tdi_i,
  input  wire                dr_capture_i,
  input  wire                dr_shift_i,
  input  wire                dr_update_i,
  input  wire dbg_pkg::dmi_rsp_t rsp_i,
  output logic               tdo_o,
  output logic               req_valid_o,
  output dbg_pkg::dmi_req_t  req_o
);

  import dbg_pkg::*;

  logic [`DBG_DMI_LEN-1:0] sr_q;
  dmi_req_t                scan_req;
  logic                    op_ok;

  // Address of the previous request goes back with its result
  always_ff @(posedge jtag_tck) begin
    if (dr_capture_i) begin
      sr_q <= {req_o.addr, rsp_i.data, rsp_i.status};
    end else if (dr_shift_i) begin
      sr_q <= {tdi_i, sr_q[`DBG_DMI_LEN-1:1]};
    end
  end

  assign tdo_o    = sr_q[0];
  assign scan_req = sr_q;
  assign op_ok    = (scan_req.op == DMI_OP_READ) || (scan_req.op == DMI_OP_WRITE);

  // Nop and reserved ops are dropped here
  always_ff @(posedge jtag_tck) begin
    if (!rst_n_i) begin
      req_valid_o <= 1'b0;
      req_o       <= '0;
    end else begin
      req_valid_o <= dr_update_i && op_ok;
      if (dr_update_i && op_ok) begin
        req_o <= scan_req;
      end
    end
  end

endmodule

`default_nettype wire

//--- source/tap_ctrl.sv
/*
 * JTAG TAP controller
 * Sixteen-state TAP FSM with IR, BYPASS and IDCODE chains and the TDO select
 */

`timescale 1ns/1ps
`default_nettype none

`include "dbg_defs.svh"

module tap_ctrl (
  input  wire  jtag_tck,
  input  wire  rst_n_i,
  input  wire  tms_i,
  input  wire  tdi_i,
  input  wire  dmi_tdo_i,
  output logic tdo_o,
  output logic dr_capture_o,
  output logic dr_shift_o,
  output logic dr_update_o
);

  import dbg_pkg::*;

  tap_state_e              state_q, state_d;
  logic [`DBG_IR_LEN-1:0]  ir_q;
  logic [`DBG_IR_LEN-1:0]  ir_sr_q;
  logic [31:0]             idcode_sr_q;
  logic                    bypass_q;
  logic                    dmi_sel;

  ////////////////////
  // TAP FSM
  ////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      TEST_LOGIC_RESET: state_d = tms_i ? TEST_LOGIC_RESET : RUN_TEST_IDLE;
      RUN_TEST_IDLE:    state_d = tms_i ? SELECT_DR : RUN_TEST_IDLE;
      SELECT_DR:        state_d = tms_i ? SELECT_IR : CAPTURE_DR;
      CAPTURE_DR:       state_d = tms_i ? EXIT1_DR : SHIFT_DR;
      SHIFT_DR:         state_d = tms_i ? EXIT1_DR : SHIFT_DR;
      EXIT1_DR:         state_d = tms_i ? UPDATE_DR : PAUSE_DR;
      PAUSE_DR:         state_d = tms_i ? EXIT2_DR : PAUSE_DR;
      EXIT2_DR:         state_d = tms_i ? UPDATE_DR : SHIFT_DR;
      UPDATE_DR:        state_d = tms_i ? SELECT_DR : RUN_TEST_IDLE;
      SELECT_IR:        state_d = tms_i ? TEST_LOGIC_RESET : CAPTURE_IR;
      CAPTURE_IR:       state_d = tms_i ? EXIT1_IR : SHIFT_IR;
      SHIFT_IR:         state_d = tms_i ? EXIT1_IR : SHIFT_IR;
      EXIT1_IR:         state_d = tms_i ? UPDATE_IR : PAUSE_IR;
      PAUSE_IR:         state_d = tms_i ? EXIT2_IR : PAUSE_IR;
      EXIT2_IR:         state_d = tms_i ? UPDATE_IR : SHIFT_IR;
      UPDATE_IR:        state_d = tms_i ? SELECT_DR : RUN_TEST_IDLE;
      default:          state_d = TEST_LOGIC_RESET;
    endcase
  end

  // Test-Logic-Reset keeps IDCODE selected
  always_ff @(posedge jtag_tck) begin
    if (!rst_n_i) begin
      state_q <= TEST_LOGIC_RESET;
      ir_q    <= `DBG_IR_IDCODE;
    end else begin
      state_q <= state_d;
      if (state_q == TEST_LOGIC_RESET) begin
        ir_q <= `DBG_IR_IDCODE;
      end else if (state_q == UPDATE_IR) begin
        ir_q <= ir_sr_q;
      end
    end
  end

  ////////////////////
  // Shift chains
  ////////////////////

  always_ff @(posedge jtag_tck) begin
    case (state_q)
      CAPTURE_IR: ir_sr_q <= `DBG_IR_LEN'(1);
      SHIFT_IR:   ir_sr_q <= {tdi_i, ir_sr_q[`DBG_IR_LEN-1:1]};
      CAPTURE_DR: begin
        bypass_q    <= 1'b0;
        idcode_sr_q <= `DBG_IDCODE;
      end
      SHIFT_DR: begin
        bypass_q    <= tdi_i;
        idcode_sr_q <= {tdi_i, idcode_sr_q[31:1]};
      end
      default: ;
    endcase
  end

  // DR strobes only reach the DMI chain
  assign dmi_sel      = (ir_q == `DBG_IR_DMI);
  assign dr_capture_o = dmi_sel && (state_q == CAPTURE_DR);
  assign dr_shift_o   = dmi_sel && (state_q == SHIFT_DR);
  assign dr_update_o  = dmi_sel && (state_q == UPDATE_DR);

  // Unknown instructions behave as BYPASS
  always_comb begin
    tdo_o = 1'b0;
    if (state_q == SHIFT_IR) begin
      tdo_o = ir_sr_q[0];
    end else if (state_q == SHIFT_DR) begin
      case (ir_q)
        `DBG_IR_IDCODE: tdo_o = idcode_sr_q[0];
        `DBG_IR_DMI:    tdo_o = dmi_tdo_i;
        default:        tdo_o = bypass_q;
      endcase
    end
  end

  // Five TMS-high cycles reach Test-Logic-Reset from any state
  a_tms_reset: assert property (@(posedge jtag_tck) disable iff (!rst_n_i)
    tms_i [*5] |=> (state_q == TEST_LOGIC_RESET));

endmodule

`default_nettype wire

//--- source/dbg_pkg.sv
/*
 * Debug transport types
 * TAP states, DMI and system bus payloads, SBCS register layout
 */

`default_nettype none

`include "dbg_defs.svh"

package dbg_pkg;

  // DMI operation codes
  localparam logic [1:0] DMI_OP_READ  = 2'd1;
  localparam logic [1:0] DMI_OP_WRITE = 2'd2;

  typedef enum logic [3:0] {
    TEST_LOGIC_RESET, RUN_TEST_IDLE,
    SELECT_DR, CAPTURE_DR, SHIFT_DR, EXIT1_DR, PAUSE_DR, EXIT2_DR, UPDATE_DR,
    SELECT_IR, CAPTURE_IR, SHIFT_IR, EXIT1_IR, PAUSE_IR, EXIT2_IR, UPDATE_IR
  } tap_state_e;

  typedef struct packed {
    logic [`DBG_DMI_AW-1:0] addr;
    logic [`DBG_DMI_DW-1:0] data;
    logic [1:0]             op;
  } dmi_req_t;

  typedef struct packed {
    logic [`DBG_DMI_DW-1:0] data;
    logic [1:0]             status;
  } dmi_rsp_t;

  typedef struct packed {
    logic        we;
    logic [31:0] addr;
    logic [31:0] wdata;
  } sb_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        err;
  } sb_rsp_t;

  // Only the supported SBCS fields, the rest read as zero
  typedef struct packed {
    logic [10:0] rsvd_hi;
    logic        sbreadonaddr;
    logic [2:0]  sbaccess;
    logic        sbautoincrement;
    logic        sbreadondata;
    logic [2:0]  sberror;
    logic [11:0] rsvd_lo;
  } sbcs_t;

endpackage

`default_nettype wire

//--- source/dbg_defs.svh
/*
 * Debug transport constants
 * JTAG instruction codes, IDCODE, DMI geometry, debug register map, memory depth
 */

`ifndef DBG_DEFS_SVH
`define DBG_DEFS_SVH

// TAP instruction register
`define DBG_IR_LEN        5
`define DBG_IR_IDCODE     5'h01
`define DBG_IR_DMI        5'h11
`define DBG_IR_BYPASS     5'h1f

// Version, part number and manufacturer fields, LSB fixed to 1
`define DBG_IDCODE        32'h2000_1db3

// DMI scan chain, address + data + op
`define DBG_DMI_AW        7
`define DBG_DMI_DW        32
`define DBG_DMI_LEN       41

// Debug module register addresses
`define DBG_ADDR_DMCONTROL 7'h10
`define DBG_ADDR_SBCS      7'h38
`define DBG_ADDR_SBADDR0   7'h39
`define DBG_ADDR_SBDATA0   7'h3c

// System bus memory, 32-bit words
`define DBG_MEM_WORDS     16

`endif
